//--- compile.f
+incdir+.
ctrlStatePkg.sv
armInstrPkg.sv
instrDecoder.sv
sequencer.sv
signalEncoder.sv
controlUnit.sv
controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module controlUnitTb -o controlUnitSim
./obj_dir/controlUnitSim

//--- controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Reference model of the control unit, stepped once per clock

ctrlState_t modelState = stReset;
instr_t modelIr = '0; // Instruction held for the execute state

logic expFrLd;
logic expRfLd;
logic expIrLd;
logic expMarLd;
logic expMdrLd;
logic expRW;
logic expMov;
logic expMc;
logic expMd;
logic expMe;
logic [1:0] expMaSel;
logic [1:0] expMbSel;
logic [4:0] expOp;

// Imm wins over a nonzero shift field
function automatic logic [1:0] kindOf(input instr_t inst);
	if (inst[25])
		return 2'd1;
	else if (inst[11:4] != 8'h00)
		return 2'd2;
	return 2'd0;
endfunction

function automatic ctrlState_t execStateOf(input instr_t inst);
	int k;
	int kind;
	int s;
	int n;
	k = int'(inst[24:21]);
	kind = int'(kindOf(inst));
	s = inst[20] ? 1 : 0;
	if (k < 8)
		n = int'(execArithBase) + 6 * k + kind + 3 * s;
	else if (k < 12)
		n = int'(execTestBase) + 3 * (k - 8) + kind; // S ignored
	else
		n = int'(execLogicBase) + 6 * (k - 12) + kind + 3 * s;
	return ctrlState_t'(n);
endfunction

function automatic ctrlState_t nextStateOf(input ctrlState_t st, input logic c,
	input logic m, input instr_t inst);
	case (st)
		stReset:
			return stFetchAddr;
		stFetchAddr:
			return stFetchWait;
		stFetchWait:
			return m ? stFetchLoad : stFetchWait;
		stFetchLoad:
			return stDecode;
		stDecode:
			return (c && inst[27:26] == 2'b00) ? execStateOf(inst) : stFetchAddr;
		default:
			return stFetchAddr;
	endcase
endfunction

task automatic predictOutputs(input ctrlState_t st, input instr_t inst);
	logic [3:0] k;
	logic isTest;
	k = inst[24:21];
	isTest = (k[3:2] == 2'b10);
	{expFrLd, expRfLd, expIrLd, expMarLd, expMdrLd} = 5'b00000;
	{expRW, expMov, expMc, expMd, expMe} = 5'b00000;
	expMaSel = 2'd0;
	expMbSel = 2'd0;
	expOp = 5'd0;
	case (st)
		stReset:
		begin
			expRfLd = 1'b1;
			expMbSel = 2'd3;
			expMc = 1'b1;
			expMd = 1'b1;
			expOp = opReset;
		end
		stFetchAddr:
		begin
			expMarLd = 1'b1;
			expMaSel = 2'd2;
			expMd = 1'b1;
			expOp = opPassPc;
		end
		stFetchWait:
		begin
			expRW = 1'b1;
			expMov = 1'b1;
			expMaSel = 2'd2;
		end
		stFetchLoad:
		begin
			{expRW, expMov, expIrLd, expRfLd} = 4'b1111;
			expMaSel = 2'd2;
			expMc = 1'b1;
			expMd = 1'b1;
			expOp = opIncPc;
		end
		stDecode:
			expOp = 5'd0;
		default:
		begin
			expFrLd = inst[20] || isTest;
			expRfLd = !isTest;
			expMbSel = (kindOf(inst) != 2'd0) ? 2'd1 : 2'd0;
			expOp = {1'b0, k};
		end
	endcase
endtask

`endif

//--- controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;

	import ctrlStatePkg::*;
	import armInstrPkg::*;

	localparam int numInstr = 400;
	localparam int timeoutCycles = numInstr * (6 + 8) + 20;
	localparam int midResetAt = 200; // Instruction count for the mid-run clr

	logic clk = 1'b0;
	logic clr;
	instr_t ir;
	logic cond;
	logic moc;
	logic frLd;
	logic rfLd;
	logic irLd;
	logic marLd;
	logic mdrLd;
	logic rW;
	logic mov;
	logic mc;
	logic md;
	logic me;
	muxSel_t maSel;
	muxSel_t mbSel;
	aluOp_t op;

	logic [31:0] rngState = 32'd54;
	logic seenMarLd = 1'b0;
	logic seenMov = 1'b0;
	logic seenIrLd = 1'b0;
	logic [2:0] waitLeft = 3'd0;
	logic midResetDone = 1'b0;
	int clrHold = 0;
	int instrCount = 0;
	int execCount = 0;
	int skipCount = 0;
	int cycleCount = 0;

	`include "controlModel.svh"

	controlUnit u_dut (
		.clk(clk),
		.clr(clr),
		.ir(ir),
		.cond(cond),
		.moc(moc),
		.frLd(frLd),
		.rfLd(rfLd),
		.irLd(irLd),
		.marLd(marLd),
		.mdrLd(mdrLd),
		.rW(rW),
		.mov(mov),
		.mc(mc),
		.md(md),
		.me(me),
		.maSel(maSel),
		.mbSel(mbSel),
		.op(op)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
			$display("tests failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// One rising edge of stimulus, based on what the last falling edge saw
	task automatic driveCycle();
		logic [31:0] word;
		logic [31:0] pick;
		if (clrHold != 0)
		begin
			clrHold = clrHold - 1;
			if (clrHold == 0)
				clr <= 1'b0;
		end
		else if (instrCount == midResetAt && !midResetDone)
		begin
			clr <= 1'b1;
			clrHold = 3;
			midResetDone = 1'b1;
		end
		if (seenIrLd)
		begin
			word = nextRandom();
			pick = nextRandom();
			if (pick[1:0] != 2'b00)
				word[27:26] = 2'b00; // Data-processing class
			if (pick[3:2] == 2'b00)
				word[11:4] = 8'h00; // Plain register operand
			ir <= word;
			cond <= pick[4];
			instrCount++;
		end
		if (seenMarLd)
		begin
			pick = nextRandom();
			waitLeft = pick[2:0];
			moc <= (pick[2:0] == 3'd0);
		end
		else if (seenMov && !seenIrLd)
		begin
			if (waitLeft == 3'd0)
				moc <= 1'b0; // Unit leaves the wait now
			else
			begin
				waitLeft = waitLeft - 3'd1;
				moc <= (waitLeft == 3'd0);
			end
		end
		else
		begin
			pick = nextRandom();
			moc <= pick[0]; // Ignored outside the wait
		end
	endtask

	always @(posedge clk or posedge clr)
	begin
		if (clr)
			modelState = stReset;
		else
		begin
			if (modelState == stDecode)
			begin
				modelIr = ir;
				if (cond && ir[27:26] == 2'b00)
					execCount++;
				else
					skipCount++;
			end
			modelState = nextStateOf(modelState, cond, moc, ir);
		end
	end

	always @(negedge clk)
	begin
		predictOutputs(modelState, modelIr);
		checkValue("frLd", 8'(frLd), 8'(expFrLd));
		checkValue("rfLd", 8'(rfLd), 8'(expRfLd));
		checkValue("irLd", 8'(irLd), 8'(expIrLd));
		checkValue("marLd", 8'(marLd), 8'(expMarLd));
		checkValue("mdrLd", 8'(mdrLd), 8'(expMdrLd));
		checkValue("rW", 8'(rW), 8'(expRW));
		checkValue("mov", 8'(mov), 8'(expMov));
		checkValue("mc", 8'(mc), 8'(expMc));
		checkValue("md", 8'(md), 8'(expMd));
		checkValue("me", 8'(me), 8'(expMe));
		checkValue("maSel", 8'(maSel), 8'(expMaSel));
		checkValue("mbSel", 8'(mbSel), 8'(expMbSel));
		checkValue("op", 8'(op), 8'(expOp));
		seenMarLd = marLd;
		seenMov = mov;
		seenIrLd = irLd;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
		begin
			$display("run did not finish within %0d cycles", timeoutCycles);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		clr <= 1'b1;
		ir <= '0;
		cond <= 1'b0;
		moc <= 1'b0;
		repeat (10) @(posedge clk);
		clr <= 1'b0;
		while (instrCount < numInstr)
		begin
			@(posedge clk);
			driveCycle();
		end
		while (!seenMarLd) // Let the last instruction finish
		begin
			@(posedge clk);
			driveCycle();
		end
		if (execCount == 0 || skipCount == 0)
		begin
			$display("no executed or no skipped instruction was seen");
			$display("tests failed");
			$fatal(1, "flow not covered");
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input logic clk,
	input logic clr,
	input armInstrPkg::instr_t ir,
	input logic cond,
	input logic moc,
	output logic frLd,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic rW,
	output logic mov,
	output logic mc,
	output logic md,
	output logic me,
	output ctrlStatePkg::muxSel_t maSel,
	output ctrlStatePkg::muxSel_t mbSel,
	output ctrlStatePkg::aluOp_t op
);

	import ctrlStatePkg::*;

	logic isDataProc;
	ctrlState_t execState;
	ctrlState_t state;

	instrDecoder u_decoder (
		.ir(ir),
		.isDataProc(isDataProc),
		.execState(execState)
	);

	sequencer u_sequencer (
		.clk(clk),
		.clr(clr),
		.cond(cond),
		.moc(moc),
		.isDataProc(isDataProc),
		.execState(execState),
		.state(state)
	);

	signalEncoder u_encoder (
		.state(state),
		.frLd(frLd),
		.rfLd(rfLd),
		.irLd(irLd),
		.marLd(marLd),
		.mdrLd(mdrLd),
		.rW(rW),
		.mov(mov),
		.mc(mc),
		.md(md),
		.me(me),
		.maSel(maSel),
		.mbSel(mbSel),
		.op(op)
	);

endmodule

//--- signalEncoder.sv
`timescale 1ns/100ps

module signalEncoder (
	input ctrlStatePkg::ctrlState_t state,
	output logic frLd,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic rW,
	output logic mov,
	output logic mc,
	output logic md,
	output logic me,
	output ctrlStatePkg::muxSel_t maSel,
	output ctrlStatePkg::muxSel_t mbSel,
	output ctrlStatePkg::aluOp_t op
);

	import ctrlStatePkg::*;

	ctrlState_t groupBase;
	ctrlState_t rel;
	logic [2:0] slot;
	logic [2:0] inGroup;
	logic isExec;
	logic isTest;
	logic execS;
	logic [1:0] execKind;
	logic [3:0] execOpcode;

	assign isExec = (state >= execArithBase) && (state <= execEndState);
	assign isTest = (state >= execTestBase) && (state < execLogicBase);

	always_comb
	begin
		if (state >= execLogicBase)
			groupBase = execLogicBase;
		else if (isTest)
			groupBase = execTestBase;
		else
			groupBase = execArithBase;
	end

	assign rel = state - groupBase;
	assign slot = 3'(isTest ? rel / narrowStride : rel / wideStride);
	assign inGroup = 3'(isTest ? rel % narrowStride : rel % wideStride);
	assign execS = !isTest && (inGroup >= 3'(sStateOffset));
	assign execKind = execS ? 2'(inGroup - 3'(sStateOffset)) : inGroup[1:0];

	always_comb
	begin
		if (state >= execLogicBase)
			execOpcode = {2'b11, slot[1:0]};
		else if (isTest)
			execOpcode = {2'b10, slot[1:0]};
		else
			execOpcode = {1'b0, slot};
	end

	always_comb
	begin
		frLd = 1'b0;
		rfLd = 1'b0;
		irLd = 1'b0;
		marLd = 1'b0;
		mdrLd = 1'b0;
		rW = 1'b0;
		mov = 1'b0;
		mc = 1'b0;
		md = 1'b0;
		me = 1'b0;
		maSel = 2'd0;
		mbSel = 2'd0;
		op = '0;
		case (state)
			stReset:
			begin
				rfLd = 1'b1;
				mbSel = 2'd3;
				mc = 1'b1;
				md = 1'b1;
				op = opReset;
			end
			stFetchAddr:
			begin
				marLd = 1'b1;
				maSel = 2'd2; // Address from PC
				md = 1'b1;
				op = opPassPc;
			end
			stFetchWait:
			begin
				rW = 1'b1;
				mov = 1'b1;
				maSel = 2'd2;
			end
			stFetchLoad:
			begin
				rW = 1'b1;
				mov = 1'b1;
				irLd = 1'b1;
				rfLd = 1'b1; // PC + 4 written back
				maSel = 2'd2;
				mc = 1'b1;
				md = 1'b1;
				op = opIncPc;
			end
			default:
			begin
				if (isExec)
				begin
					frLd = execS || isTest;
					rfLd = !isTest;
					mbSel = (execKind != 2'd0) ? 2'd1 : 2'd0;
					op = {1'b0, execOpcode};
				end
			end
		endcase
	end

	// Instruction load only during an active memory read, never with an address load
	always_comb
	begin
		assert (!irLd || mov) else $error("irLd without mov in state %0d", state);
		assert (!(marLd && irLd)) else $error("marLd and irLd together in state %0d", state);
	end

endmodule

//--- sequencer.sv
`timescale 1ns/100ps

module sequencer (
	input logic clk,
	input logic clr,
	input logic cond,
	input logic moc,
	input logic isDataProc,
	input ctrlStatePkg::ctrlState_t execState,
	output ctrlStatePkg::ctrlState_t state
);

	import ctrlStatePkg::*;

	localparam int waitCountWidth = $clog2(maxFetchWait) + 1;

	ctrlState_t nextState;
	logic [waitCountWidth-1:0] waitCount;

	always_ff @(posedge clk or posedge clr)
	begin
		if (clr)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			stReset:
				nextState = stFetchAddr;
			stFetchAddr:
				nextState = stFetchWait;
			stFetchWait:
				nextState = moc ? stFetchLoad : stFetchWait; // Hold until memory done
			stFetchLoad:
				nextState = stDecode;
			stDecode:
			begin
				if (cond && isDataProc)
					nextState = execState;
				else
					nextState = stFetchAddr; // Skip the instruction
			end
			default:
				nextState = stFetchAddr; // Every execute state ends here
		endcase
	end

	// Cycles already spent in the memory wait
	always_ff @(posedge clk or posedge clr)
	begin
		if (clr)
			waitCount <= '0;
		else if ((state == stFetchWait) && (nextState == stFetchWait))
			waitCount <= waitCount + 1'b1;
		else
			waitCount <= '0;
	end

	stateInRange: assert property (
		@(posedge clk) disable iff (clr)
		state <= lastState
	) else $error("state %0d is outside the state numbering", state);

	fetchWaitBounded: assert property (
		@(posedge clk) disable iff (clr)
		waitCount < waitCountWidth'(maxFetchWait)
	) else $error("memory wait longer than %0d cycles", maxFetchWait);

endmodule

//--- instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input armInstrPkg::instr_t ir,
	output logic isDataProc,
	output ctrlStatePkg::ctrlState_t execState
);

	import armInstrPkg::*;
	import ctrlStatePkg::*;

	opcode_t opcode;
	operandKind_t kind;
	logic sFlag;
	logic [shiftHi-shiftLo:0] shiftField;
	ctrlState_t kindOffset;
	ctrlState_t sOffset;
	ctrlState_t groupIndex;

	assign isDataProc = (ir[classHi:classLo] == 2'b00); // Class 00 only
	assign opcode = ir[opcodeHi:opcodeLo];
	assign sFlag = ir[sBit];
	assign shiftField = ir[shiftHi:shiftLo];

	always_comb
	begin
		if (ir[immBit])
			kind = kindImm;
		else if (shiftField != '0)
			kind = kindShift;
		else
			kind = kindReg;
	end

	assign kindOffset = ctrlState_t'(kind);
	assign sOffset = sFlag ? sStateOffset : '0;

	// Position of the opcode inside its group
	always_comb
	begin
		if (opcode < dpTst)
			groupIndex = ctrlState_t'(opcode);
		else
			groupIndex = ctrlState_t'(opcode[1:0]);
	end

	always_comb
	begin
		if (opcode < dpTst)
		begin
			execState = execArithBase + groupIndex * wideStride + kindOffset + sOffset;
		end
		else if (opcode < dpOrr)
		begin
			// Compare group writes flags only, S has no own state
			execState = execTestBase + groupIndex * narrowStride + kindOffset;
		end
		else
		begin
			execState = execLogicBase + groupIndex * wideStride + kindOffset + sOffset;
		end
	end

endmodule

//--- armInstrPkg.sv
package armInstrPkg;

	typedef logic [31:0] instr_t;
	typedef logic [3:0] opcode_t;

	typedef enum logic [1:0]
	{
		kindReg = 2'd0,
		kindImm = 2'd1,
		kindShift = 2'd2
	} operandKind_t;

	// Field positions in the instruction word
	localparam int classHi = 27;
	localparam int classLo = 26;
	localparam int immBit = 25;
	localparam int opcodeHi = 24;
	localparam int opcodeLo = 21;
	localparam int sBit = 20;
	localparam int shiftHi = 11;
	localparam int shiftLo = 4;

	localparam opcode_t dpAnd = 4'd0;
	localparam opcode_t dpEor = 4'd1;
	localparam opcode_t dpSub = 4'd2;
	localparam opcode_t dpRsb = 4'd3;
	localparam opcode_t dpAdd = 4'd4;
	localparam opcode_t dpAdc = 4'd5;
	localparam opcode_t dpSbc = 4'd6;
	localparam opcode_t dpRsc = 4'd7;
	localparam opcode_t dpTst = 4'd8;  // First flag-only opcode
	localparam opcode_t dpTeq = 4'd9;
	localparam opcode_t dpCmp = 4'd10;
	localparam opcode_t dpCmn = 4'd11;
	localparam opcode_t dpOrr = 4'd12;
	localparam opcode_t dpMov = 4'd13;
	localparam opcode_t dpBic = 4'd14;
	localparam opcode_t dpMvn = 4'd15;

endpackage

//--- ctrlStatePkg.sv
package ctrlStatePkg;

	localparam int stateWidth = 10;
	localparam int aluOpWidth = 5;
	localparam int muxSelWidth = 2;

	typedef logic [stateWidth-1:0] ctrlState_t;
	typedef logic [aluOpWidth-1:0] aluOp_t;
	typedef logic [muxSelWidth-1:0] muxSel_t;

	// Fetch and decode states
	localparam ctrlState_t stReset = 10'd0;
	localparam ctrlState_t stFetchAddr = 10'd1;
	localparam ctrlState_t stFetchWait = 10'd2;
	localparam ctrlState_t stFetchLoad = 10'd3;
	localparam ctrlState_t stDecode = 10'd4;

	localparam ctrlState_t execArithBase = 10'd5;  // Opcodes 0 to 7
	localparam ctrlState_t execTestBase = 10'd53;  // Opcodes 8 to 11, no S variant
	localparam ctrlState_t execLogicBase = 10'd65; // Opcodes 12 to 15

	// Reg, Imm, Shift and then the same three with S set
	localparam ctrlState_t wideStride = 10'd6;
	localparam ctrlState_t narrowStride = 10'd3;
	localparam ctrlState_t sStateOffset = 10'd3;

	// Last execute state in use
	localparam ctrlState_t execEndState = execLogicBase + 4 * wideStride - 1;

	// States above execEndState are kept free in the numbering
	localparam ctrlState_t lastState = 10'd100;

	// Longest memory wait that is still legal
	localparam int maxFetchWait = 64;

	localparam aluOp_t opReset = 5'b01101;
	localparam aluOp_t opPassPc = 5'b10000;
	localparam aluOp_t opIncPc = 5'b10001;

endpackage
